//--- list.f
verilog/host_pkg.sv
verilog/exec_pkg.sv
verilog/fx2_fifo_port.sv
verilog/cmd_decode.sv
verilog/cmd_execute.sv
verilog/result_report.sv
verilog/hex595_display.sv
verilog/cmd_top.sv
test/tb_fx2_model.sv
test/tb_cmd_top.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log &&
  verilator --binary --timing --timescale 1ns/100ps -Wno-fatal \
    --top-module tb_cmd_top -f list.f > build.log 2>&1 &&
  ./obj_dir/Vtb_cmd_top > sim.log 2>&1
cat sim.log 2>/dev/null || echo "Build failed, see build.log"
grep -qx "Test OK" sim.log 2>/dev/null && exit 0 || exit 1

//--- test/cmd_trace.txt
// Columns: command word, response expected (1 or 0), response, display value, LED
// One test per line, all values hex; a response is only checked when column two is 1
01001234 0 0000 1234 0  // write r0, r0 is shown after reset
03000000 1 1234 1234 0  // read r0
0101FFF0 0 0000 1234 0  // write r1
02010120 0 0000 1234 0  // r1 = r1 + 20 wraps
03010000 1 0010 1234 0  // read r1
04010000 0 0000 0010 0  // show r1
0101ABCD 0 0000 ABCD 0  // write to shown register
01025555 0 0000 ABCD 0  // other register, display holds
07000000 0 0000 ABCD 1  // unknown opcode
01049999 0 0000 ABCD 1  // address 4
03020000 1 5555 ABCD 0  // valid read clears the LED
02000501 0 0000 ABCD 1  // add with source 5
03000000 1 1234 ABCD 0  // r0 untouched by the bad write
020302FF 0 0000 ABCD 0  // r3 = r2 + FF
04030000 0 0000 5654 0  // show r3

//--- test/tb_cmd_top.sv
module tb_cmd_top;
  timeunit 1ns;
  timeprecision 100ps;
  import host_pkg::*;
  import exec_pkg::*;

  localparam int         FIELDS       = 5;      // Values per trace line
  localparam int         MAX_TESTS    = 64;
  localparam logic [7:0] END_OPCODE   = 8'hEE;  // Marks entries the trace left empty
  localparam int         TEST_NS      = 3000;
  localparam int         EXTRA_NS     = 10000;
  localparam int         INTAKE_LIMIT = 100;    // Cycles
  localparam int         PKT_LIMIT    = 200;
  localparam int         FRAME_LIMIT  = 400;
  localparam int         SETTLE       = 5;      // Four pipeline cycles plus margin

  logic        sys_clk;
  logic        sys_rst_n;
  logic        flag_empty_n;
  logic        flag_full_n;
  byte_t       fd_in;
  byte_t       fd_out;
  logic        fd_oe;
  logic        slrd;
  logic        slwr;
  logic        sloe;
  logic [1:0]  fifoadr;
  logic        pktend;
  logic        led;
  logic        segled_clk;
  logic        segled_dat;
  logic        segled_str;

  logic [31:0] trace_mem [FIELDS*MAX_TESTS];
  int          num_tests = 0;
  bit          trace_ready = 1'b0;
  int          checks = 0;
  int          errors = 0;
  int          test_errs = 0;
  int          failed_tests = 0;

  cmd_top cmd_top_inst (.*);

  tb_fx2_model fx2 (
    .sys_clk      (sys_clk),
    .flag_empty_n (flag_empty_n),
    .flag_full_n  (flag_full_n),
    .fd_in        (fd_in),
    .fd_out       (fd_out),
    .fd_oe        (fd_oe),
    .slrd         (slrd),
    .slwr         (slwr),
    .sloe         (sloe),
    .fifoadr      (fifoadr),
    .pktend       (pktend),
    .seg_clk      (segled_clk),
    .seg_dat      (segled_dat),
    .seg_str      (segled_str)
  );

  initial begin
    sys_clk = 1'b0;
    forever #5 sys_clk = ~sys_clk;
  end

  function automatic void count_error();
    errors++;
    test_errs++;
  endfunction

  task automatic check_rsp(input rsp_t got, input rsp_t exp, input int idx);
    checks++;
    if (got !== exp) begin
      count_error();
      $display("mismatch at %0t: test %0d response %h, expected %h", $time, idx, got, exp);
    end
  endtask

  task automatic check_display(input reg_val_t exp, input int idx);
    reg_val_t got;
    int       d;
    int       n;
    bit       found;
    got = '0;
    checks++;
    for (d = 0; d < 4; d++) begin
      found = 1'b0;
      for (n = 0; n < 16; n++) begin
        if (SEG_TABLE[n] == fx2.digit_code[d]) begin
          got[d*4 +: 4] = n[3:0];
          found         = 1'b1;
        end
      end
      if (!found) begin
        count_error();
        $display("mismatch at %0t: test %0d digit %0d shows segment code %h, no hex digit",
                 $time, idx, d, fx2.digit_code[d]);
      end
    end
    if (got !== exp) begin
      count_error();
      $display("mismatch at %0t: test %0d display %h, expected %h", $time, idx, got, exp);
    end
  endtask

  task automatic check_err(input logic got, input logic exp, input int idx);
    checks++;
    if (got !== exp) begin
      count_error();
      $display("mismatch at %0t: test %0d led %b, expected %b", $time, idx, got, exp);
    end
  endtask

  task automatic load_trace();
    int i;
    for (i = 0; i < FIELDS*MAX_TESTS; i++) begin
      trace_mem[i] = {END_OPCODE, 24'(i)};
    end
    $readmemh("test/cmd_trace.txt", trace_mem);
    while (num_tests < MAX_TESTS && trace_mem[num_tests*FIELDS][31:24] != END_OPCODE) begin
      num_tests++;
    end
    if (num_tests == 0) begin
      errors++;
      $display("The trace file test/cmd_trace.txt holds no tests");
    end
    trace_ready = 1'b1;
  endtask

  task automatic run_test(input int idx);
    logic [31:0] word;
    logic        has_rsp;
    rsp_t        exp_rsp;
    reg_val_t    exp_disp;
    logic        exp_led;
    rsp_t        got;
    int          base;
    int          frames0;
    int          cnt;
    int          len;
    int          b;
    word      = trace_mem[idx*FIELDS];
    has_rsp   = trace_mem[idx*FIELDS+1][0];
    exp_rsp   = trace_mem[idx*FIELDS+2][15:0];
    exp_disp  = trace_mem[idx*FIELDS+3][15:0];
    exp_led   = trace_mem[idx*FIELDS+4][0];
    test_errs = 0;
    @(posedge sys_clk);
    base = fx2.bytes_taken;
    for (b = 3; b >= 0; b--) begin
      fx2.queue_byte(word[b*8 +: 8], int'($urandom % 4));  // MSB first, random gaps
    end
    cnt = 0;
    while (fx2.bytes_taken < base + 4 && cnt < INTAKE_LIMIT) begin
      @(negedge sys_clk);
      cnt++;
    end
    if (fx2.bytes_taken < base + 4) begin
      count_error();
      $display("test %0d: the DUT did not take all four command bytes", idx);
    end
    repeat (SETTLE) @(negedge sys_clk);
    check_err(led, exp_led, idx);
    frames0 = fx2.frame_cnt;
    if (has_rsp) begin
      cnt = 0;
      while (fx2.packets_waiting() == 0 && cnt < PKT_LIMIT) begin
        @(negedge sys_clk);
        cnt++;
      end
      if (fx2.packets_waiting() == 0) begin
        count_error();
        $display("test %0d: no response packet arrived for the read", idx);
      end else begin
        fx2.take_packet(len, got);
        if (len != 2) begin
          count_error();
          $display("test %0d: response packet holds %0d bytes instead of 2", idx, len);
        end else begin
          check_rsp(got, exp_rsp, idx);
        end
      end
    end
    // Five strobes make sure all four digits were loaded after the update
    cnt = 0;
    while (fx2.frame_cnt < frames0 + 5 && cnt < FRAME_LIMIT) begin
      @(negedge sys_clk);
      cnt++;
    end
    if (fx2.frame_cnt < frames0 + 5) begin
      count_error();
      $display("test %0d: the display chain stopped refreshing", idx);
    end else begin
      check_display(exp_disp, idx);
    end
    if (fx2.packets_waiting() != 0) begin
      count_error();
      $display("test %0d: the DUT sent a response packet that was not expected", idx);
      while (fx2.packets_waiting() != 0) fx2.take_packet(len, got);
    end
    if (test_errs != 0) failed_tests++;
    $display("test %0d cmd %h: %s", idx, word, (test_errs == 0) ? "pass" : "fail");
  endtask

  initial begin
    int i;
    sys_rst_n = 1'b0;
    void'($urandom(32'h1c4d));
    load_trace();
    for (i = 0; i < fx2.stall_len(); i++) begin
      fx2.set_stall(i, ($urandom % 4) == 0);  // In endpoint full about one cycle in four
    end
    repeat (4) @(posedge sys_clk);
    @(negedge sys_clk);
    sys_rst_n = 1'b1;
    for (i = 0; i < num_tests; i++) begin
      run_test(i);
    end
    if (fx2.proto_errs != 0) begin
      errors++;
      $display("The FX2 model saw %0d strobes with a wrong FIFO address or bus state",
               fx2.proto_errs);
    end
    $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
             num_tests, failed_tests, checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  initial begin
    wait (trace_ready);
    #(num_tests * TEST_NS + EXTRA_NS);
    $display("Watchdog expired after %0d ns, the run did not finish",
             num_tests * TEST_NS + EXTRA_NS);
    $display("Test FAILED");
    $finish;
  end

endmodule

//--- test/tb_fx2_model.sv
module tb_fx2_model (
  input  logic            sys_clk,
  output logic            flag_empty_n,
  output logic            flag_full_n,
  output host_pkg::byte_t fd_in,
  input  host_pkg::byte_t fd_out,
  input  logic            fd_oe,
  input  logic            slrd,
  input  logic            slwr,
  input  logic            sloe,
  input  logic [1:0]      fifoadr,
  input  logic            pktend,
  input  logic            seg_clk,
  input  logic            seg_dat,
  input  logic            seg_str
);
  timeunit 1ns;
  timeprecision 100ps;
  import host_pkg::*;

  localparam int STALL_LEN = 1024;

  byte_t       out_q[$];       // Host to FPGA bytes
  int          gap_q[$];       // Idle cycles before each byte
  byte_t       cur_pkt[$];     // In endpoint packet being filled
  int          pkt_len_q[$];
  rsp_t        pkt_val_q[$];
  bit          stall_map [STALL_LEN];
  int          cyc = 0;
  int          bytes_taken = 0;
  int          proto_errs = 0;
  int          frame_cnt = 0;
  byte_t       digit_code [4];  // Latched segment code per digit
  logic [15:0] chain;           // Two cascaded 595s
  logic        seg_clk_prev = 1'b0;

  function automatic void queue_byte(input byte_t b, input int gap);
    out_q.push_back(b);
    gap_q.push_back(gap);
  endfunction

  function automatic void set_stall(input int idx, input bit full);
    stall_map[idx % STALL_LEN] = full;
  endfunction

  function automatic int stall_len();
    return STALL_LEN;
  endfunction

  function automatic int packets_waiting();
    return pkt_len_q.size();
  endfunction

  function automatic void take_packet(output int len, output rsp_t val);
    len = pkt_len_q.pop_front();
    val = pkt_val_q.pop_front();
  endfunction

  function automatic void report_protocol(input string what);
    proto_errs++;
    $display("FX2 protocol error at %0t: %s", $time, what);
  endfunction

  function automatic void drive_inputs();
    flag_full_n  = !stall_map[cyc % STALL_LEN];
    cyc          = cyc + 1;
    flag_empty_n = 1'b0;
    if (out_q.size() > 0) begin
      if (gap_q[0] > 0) begin
        gap_q[0] = gap_q[0] - 1;  // Host still busy
      end else begin
        flag_empty_n = 1'b1;
        fd_in        = out_q[0];
      end
    end
  endfunction

  // Everything here is what the next rising edge will act on
  function automatic void sample_outputs();
    rsp_t val;
    int   d;
    if (sloe && slrd && flag_empty_n) begin
      if (fifoadr != FIFOADR_OUT_EP) begin
        report_protocol("a byte was read without the out endpoint address");
      end
      out_q.delete(0);
      gap_q.delete(0);
      bytes_taken++;
    end
    if (slwr) begin
      if (!fd_oe || !flag_full_n || fifoadr != FIFOADR_IN_EP) begin
        report_protocol("a byte was written with the bus off, the FIFO full or a wrong address");
      end
      cur_pkt.push_back(fd_out);
    end
    if (pktend) begin
      if (fifoadr != FIFOADR_IN_EP) begin
        report_protocol("a packet end came without the in endpoint address");
      end
      val = '0;
      if (cur_pkt.size() >= 2) val = {cur_pkt[0], cur_pkt[1]};  // High byte first
      pkt_len_q.push_back(cur_pkt.size());
      pkt_val_q.push_back(val);
      cur_pkt.delete();
    end
    if (seg_clk && !seg_clk_prev) chain = {chain[14:0], seg_dat};
    seg_clk_prev = seg_clk;
    if (seg_str) begin
      for (d = 0; d < 4; d++) begin
        if (chain[d]) digit_code[d] = chain[15:8];  // One-hot select in the low byte
      end
      frame_cnt++;
    end
  endfunction

  initial begin
    flag_empty_n = 1'b0;
    flag_full_n  = 1'b1;
    fd_in        = '0;
    forever begin
      @(negedge sys_clk);
      drive_inputs();
      #1;
      sample_outputs();
    end
  end

endmodule

//--- verilog/cmd_decode.sv
module cmd_decode (
  input  logic                   sys_clk,
  input  logic                   sys_rst_n,
  input  host_pkg::cmd_word_u    cmd_word,
  input  logic                   cmd_valid,
  output exec_pkg::decoded_cmd_t dcmd,
  output logic                   dec_valid
);
  import exec_pkg::*;

  decoded_cmd_t dcmd_next;
  logic         reg_ok;
  logic         alu_ok;

  assign reg_ok = cmd_word.reg_form.addr < 8'(NUM_REGS);
  assign alu_ok = (cmd_word.alu_form.dst < 8'(NUM_REGS)) &&
                  (cmd_word.alu_form.src < 8'(NUM_REGS));

  always_comb begin
    dcmd_next      = '0;
    dcmd_next.kind = KIND_BAD;
    dcmd_next.dst  = reg_idx_t'(cmd_word.reg_form.addr);  // Same byte as the add destination
    if (cmd_word.alu_form.opcode == OP_ADD) begin
      dcmd_next.src     = reg_idx_t'(cmd_word.alu_form.src);
      dcmd_next.operand = {8'h00, cmd_word.alu_form.imm};  // Zero-extended immediate
    end else begin
      dcmd_next.operand = cmd_word.reg_form.value;
    end
    case (cmd_word.reg_form.opcode)
      OP_WRITE: if (reg_ok) dcmd_next.kind = KIND_WRITE;
      OP_READ:  if (reg_ok) dcmd_next.kind = KIND_READ;
      OP_SHOW:  if (reg_ok) dcmd_next.kind = KIND_SHOW;
      OP_ADD:   if (alu_ok) dcmd_next.kind = KIND_ADD;
      default:  dcmd_next.kind = KIND_BAD;
    endcase
  end

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= cmd_valid;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (cmd_valid) begin
      dcmd <= dcmd_next;
    end
  end

endmodule

//--- verilog/cmd_execute.sv
module cmd_execute (
  input  logic                   sys_clk,
  input  logic                   sys_rst_n,
  input  exec_pkg::decoded_cmd_t dcmd,
  input  logic                   dec_valid,
  output exec_pkg::exec_result_t result,
  output logic                   res_valid
);
  import exec_pkg::*;

  reg_val_t     regs [NUM_REGS];
  reg_val_t     sum;
  exec_result_t res_next;
  logic         writes_reg;

  assign sum        = regs[dcmd.src] + dcmd.operand;  // Wraps at 16 bits
  assign writes_reg = (dcmd.kind == KIND_WRITE) || (dcmd.kind == KIND_ADD);

  always_comb begin
    res_next      = '0;
    res_next.kind = dcmd.kind;
    res_next.dst  = dcmd.dst;
    res_next.bad  = (dcmd.kind == KIND_BAD);
    case (dcmd.kind)
      KIND_WRITE: res_next.value = dcmd.operand;
      KIND_ADD:   res_next.value = sum;
      KIND_READ,
      KIND_SHOW:  res_next.value = regs[dcmd.dst];
      default:    res_next.value = '0;  // Bad command returns nothing
    endcase
  end

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
      res_valid <= 1'b0;
    end else begin
      res_valid <= dec_valid;
      if (dec_valid && writes_reg) begin
        regs[dcmd.dst] <= res_next.value;
      end
    end
  end

  always_ff @(posedge sys_clk) begin
    if (dec_valid) begin
      result <= res_next;
    end
  end

endmodule

//--- verilog/cmd_top.sv
module cmd_top (
  input  logic            sys_clk,
  input  logic            sys_rst_n,
  input  logic            flag_empty_n,
  input  logic            flag_full_n,
  input  host_pkg::byte_t fd_in,
  output host_pkg::byte_t fd_out,
  output logic            fd_oe,   // Board wrapper drives the FD pads from this
  output logic            slrd,
  output logic            slwr,
  output logic            sloe,
  output logic [1:0]      fifoadr,
  output logic            pktend,
  output logic            led,     // Bad command indicator
  output logic            segled_clk,
  output logic            segled_dat,
  output logic            segled_str
);
  import host_pkg::*;
  import exec_pkg::*;

  cmd_word_u    cmd_word;
  logic         cmd_valid;
  decoded_cmd_t dcmd;
  logic         dec_valid;
  exec_result_t result;
  logic         res_valid;
  rsp_t         rsp;
  logic         rsp_valid;
  reg_val_t     show_value;

  fx2_fifo_port fx2_fifo_port_inst (
    .sys_clk      (sys_clk),
    .sys_rst_n    (sys_rst_n),
    .flag_empty_n (flag_empty_n),
    .flag_full_n  (flag_full_n),
    .fd_in        (fd_in),
    .fd_out       (fd_out),
    .fd_oe        (fd_oe),
    .slrd         (slrd),
    .slwr         (slwr),
    .sloe         (sloe),
    .fifoadr      (fifoadr),
    .pktend       (pktend),
    .cmd_word     (cmd_word),
    .cmd_valid    (cmd_valid),
    .rsp          (rsp),
    .rsp_valid    (rsp_valid)
  );

  cmd_decode cmd_decode_inst (
    .sys_clk   (sys_clk),
    .sys_rst_n (sys_rst_n),
    .cmd_word  (cmd_word),
    .cmd_valid (cmd_valid),
    .dcmd      (dcmd),
    .dec_valid (dec_valid)
  );

  cmd_execute cmd_execute_inst (
    .sys_clk   (sys_clk),
    .sys_rst_n (sys_rst_n),
    .dcmd      (dcmd),
    .dec_valid (dec_valid),
    .result    (result),
    .res_valid (res_valid)
  );

  result_report result_report_inst (
    .sys_clk    (sys_clk),
    .sys_rst_n  (sys_rst_n),
    .result     (result),
    .res_valid  (res_valid),
    .rsp        (rsp),
    .rsp_valid  (rsp_valid),
    .show_value (show_value),
    .err        (led)
  );

  hex595_display hex595_display_inst (
    .sys_clk   (sys_clk),
    .sys_rst_n (sys_rst_n),
    .value     (show_value),
    .seg_clk   (segled_clk),
    .seg_dat   (segled_dat),
    .seg_str   (segled_str)
  );

endmodule

//--- verilog/exec_pkg.sv
package exec_pkg;

  localparam logic [7:0] OP_WRITE = 8'h01;
  localparam logic [7:0] OP_ADD   = 8'h02;
  localparam logic [7:0] OP_READ  = 8'h03;
  localparam logic [7:0] OP_SHOW  = 8'h04;

  localparam int NUM_REGS = 4;

  typedef logic [15:0] reg_val_t;
  typedef logic [$clog2(NUM_REGS)-1:0] reg_idx_t;

  typedef enum logic [2:0] {
    KIND_WRITE,
    KIND_ADD,
    KIND_READ,
    KIND_SHOW,
    KIND_BAD
  } cmd_kind_t;

  typedef struct packed {
    cmd_kind_t kind;
    reg_idx_t  dst;
    reg_idx_t  src;      // Only used by add
    reg_val_t  operand;  // Write value or zero-extended immediate
  } decoded_cmd_t;

  typedef struct packed {
    cmd_kind_t kind;
    reg_idx_t  dst;    // Lets the report stage track the shown register
    reg_val_t  value;
    logic      bad;
  } exec_result_t;

endpackage

//--- verilog/fx2_fifo_port.sv
module fx2_fifo_port (
  input  logic                sys_clk,
  input  logic                sys_rst_n,
  input  logic                flag_empty_n,  // Out endpoint holds data
  input  logic                flag_full_n,   // In endpoint has room
  input  host_pkg::byte_t     fd_in,
  output host_pkg::byte_t     fd_out,
  output logic                fd_oe,
  output logic                slrd,
  output logic                slwr,
  output logic                sloe,
  output logic [1:0]          fifoadr,
  output logic                pktend,
  output host_pkg::cmd_word_u cmd_word,
  output logic                cmd_valid,
  input  host_pkg::rsp_t      rsp,
  input  logic                rsp_valid
);
  import host_pkg::*;

  typedef enum logic [2:0] {
    ST_READ,
    ST_SETTLE,
    ST_WR_HI,
    ST_WR_LO,
    ST_PKTEND
  } port_state_t;

  // Pipeline depth from the last byte to rsp_valid seen here
  localparam int SETTLE_CYCLES = 4;

  port_state_t state;
  logic [1:0]  byte_cnt;
  logic [1:0]  settle_cnt;
  rsp_t        rsp_q;
  logic        take;

  assign slrd    = (state == ST_READ) && flag_empty_n;  // Idle while the out endpoint is empty
  assign sloe    = (state == ST_READ) || (state == ST_SETTLE);
  assign fd_oe   = (state == ST_WR_HI) || (state == ST_WR_LO);
  assign slwr    = fd_oe && flag_full_n;  // Stall while the in endpoint is full
  assign pktend  = (state == ST_PKTEND);
  assign fifoadr = (fd_oe || pktend) ? FIFOADR_IN_EP : FIFOADR_OUT_EP;
  assign fd_out  = (state == ST_WR_HI) ? rsp_q[15:8] : rsp_q[7:0];
  assign take    = slrd && sloe && flag_empty_n;

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      state      <= ST_READ;
      byte_cnt   <= '0;
      settle_cnt <= '0;
      cmd_valid  <= 1'b0;
    end else begin
      cmd_valid <= 1'b0;
      case (state)
        ST_READ: begin
          if (take) begin
            byte_cnt <= byte_cnt + 2'd1;  // Wraps back to 0 after the fourth byte
            if (byte_cnt == 2'd3) begin
              cmd_valid  <= 1'b1;
              settle_cnt <= '0;
              state      <= ST_SETTLE;
            end
          end
        end
        ST_SETTLE: begin
          settle_cnt <= settle_cnt + 2'd1;
          if (settle_cnt == 2'(SETTLE_CYCLES - 1)) begin
            state <= rsp_valid ? ST_WR_HI : ST_READ;
          end
        end
        ST_WR_HI: begin
          if (slwr) begin
            state <= ST_WR_LO;
          end
        end
        ST_WR_LO: begin
          if (slwr) begin
            state <= ST_PKTEND;
          end
        end
        ST_PKTEND: state <= ST_READ;  // Commit the short packet
        default:   state <= ST_READ;
      endcase
    end
  end

  always_ff @(posedge sys_clk) begin
    if (take) begin
      cmd_word <= cmd_word_u'({cmd_word[23:0], fd_in});  // Big-endian assembly
    end
    if (state == ST_SETTLE && rsp_valid) begin
      rsp_q <= rsp;
    end
  end

endmodule

//--- verilog/hex595_display.sv
module hex595_display (
  input  logic               sys_clk,
  input  logic               sys_rst_n,
  input  exec_pkg::reg_val_t value,
  output logic               seg_clk,
  output logic               seg_dat,
  output logic               seg_str
);
  import host_pkg::*;

  localparam int DIV_W   = $clog2(SHIFT_DIV);
  localparam int FRAME_W = 16;

  typedef enum logic [1:0] {
    ST_LOAD,
    ST_SHIFT,
    ST_STROBE
  } disp_state_t;

  disp_state_t        state;
  logic [1:0]         digit;
  logic [DIV_W-1:0]   div_cnt;
  logic [3:0]         bit_cnt;
  logic [FRAME_W-1:0] frame;
  logic [3:0]         nibble;
  logic [7:0]         digit_sel;
  logic               bit_done;

  assign nibble    = value[digit*4 +: 4];
  assign digit_sel = 8'd1 << digit;  // One-hot digit select
  assign bit_done  = (div_cnt == DIV_W'(SHIFT_DIV - 1));

  // Clock low in the first half of each bit, data moves on the falling edge
  assign seg_clk = (state == ST_SHIFT) && (div_cnt >= DIV_W'(SHIFT_DIV / 2));
  assign seg_dat = frame[FRAME_W-1];
  assign seg_str = (state == ST_STROBE);

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      state   <= ST_LOAD;
      digit   <= '0;
      div_cnt <= '0;
      bit_cnt <= '0;
    end else begin
      case (state)
        ST_LOAD: begin
          div_cnt <= '0;
          bit_cnt <= '0;
          state   <= ST_SHIFT;
        end
        ST_SHIFT: begin
          div_cnt <= div_cnt + 1'b1;
          if (bit_done) begin
            div_cnt <= '0;
            bit_cnt <= bit_cnt + 4'd1;
            if (bit_cnt == 4'(FRAME_W - 1)) begin
              state <= ST_STROBE;
            end
          end
        end
        ST_STROBE: begin
          digit <= digit + 2'd1;  // Next digit, wraps after 3
          state <= ST_LOAD;
        end
        default: state <= ST_LOAD;
      endcase
    end
  end

  always_ff @(posedge sys_clk) begin
    if (state == ST_LOAD) begin
      frame <= {SEG_TABLE[nibble], digit_sel};  // Value sampled per frame
    end else if (state == ST_SHIFT && bit_done) begin
      frame <= frame << 1;
    end
  end

endmodule

//--- verilog/host_pkg.sv
package host_pkg;

  typedef logic [7:0] byte_t;

  // Register access view of a command word
  typedef struct packed {
    logic [7:0]  opcode;
    logic [7:0]  addr;
    logic [15:0] value;
  } reg_form_t;

  // Arithmetic view, immediate in the low byte
  typedef struct packed {
    logic [7:0] opcode;
    logic [7:0] dst;
    logic [7:0] src;
    logic [7:0] imm;
  } alu_form_t;

  typedef union packed {
    reg_form_t reg_form;
    alu_form_t alu_form;
  } cmd_word_u;

  typedef logic [15:0] rsp_t;  // Sent high byte first

  localparam logic [1:0] FIFOADR_OUT_EP = 2'b00;  // EP2, host to FPGA
  localparam logic [1:0] FIFOADR_IN_EP  = 2'b10;  // EP6, FPGA to host

  // Active-low segments, bit 7 is the decimal point
  localparam byte_t SEG_TABLE [16] = '{
    8'hC0, 8'hF9, 8'hA4, 8'hB0,
    8'h99, 8'h92, 8'h82, 8'hF8,
    8'h80, 8'h90, 8'h88, 8'h83,
    8'hC6, 8'hA1, 8'h86, 8'h8E
  };

  localparam int SHIFT_DIV = 4;  // sys_clk cycles per 595 shift bit

endpackage

//--- verilog/result_report.sv
module result_report (
  input  logic                   sys_clk,
  input  logic                   sys_rst_n,
  input  exec_pkg::exec_result_t result,
  input  logic                   res_valid,
  output host_pkg::rsp_t         rsp,
  output logic                   rsp_valid,
  output exec_pkg::reg_val_t     show_value,
  output logic                   err
);
  import exec_pkg::*;

  reg_idx_t shown_reg;  // Register currently on the display
  logic     is_read;
  logic     is_show;
  logic     hits_shown;

  assign is_read    = res_valid && (result.kind == KIND_READ);
  assign is_show    = res_valid && (result.kind == KIND_SHOW);
  assign hits_shown = res_valid && (result.dst == shown_reg) &&
                      ((result.kind == KIND_WRITE) || (result.kind == KIND_ADD));

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      rsp_valid  <= 1'b0;
      shown_reg  <= '0;
      show_value <= '0;
      err        <= 1'b0;
    end else begin
      rsp_valid <= is_read;
      if (is_show) begin
        shown_reg  <= result.dst;
        show_value <= result.value;
      end else if (hits_shown) begin
        show_value <= result.value;  // Keep the digits in step with the register
      end
      if (res_valid) begin
        err <= result.bad;  // Next valid command clears it
      end
    end
  end

  always_ff @(posedge sys_clk) begin
    if (is_read) begin
      rsp <= result.value;
    end
  end

endmodule
